/* bench/fetch_monitor.sv */
`timescale 1ns/1ns

module fetch_monitor #(
    parameter int NAME_CHARS = 24
) (
    input  logic                    clk,
    input  logic                    check_en,
    input  logic                    trace_done,
    input  logic [8*NAME_CHARS-1:0] test_name,
    input  int                      line_no,
    input  logic [31:0]             exp_instr,
    input  logic [31:0]             exp_curr,
    input  logic [31:0]             exp_next,
    input  logic [31:0]             instruction_dec,
    input  logic [31:0]             pc_curr_dec,
    input  logic [31:0]             pc_next_dec,
    output int                      tests_passed,
    output int                      tests_failed,
    output logic                    report_done
);

    // Sample point, 2 ns ahead of the next rising edge
    localparam int SAMPLE_DELAY = 18;

    // Test currently being checked, empty before the first line
    logic [8*NAME_CHARS-1:0] cur_name;
    int cur_errors;
    int cur_cycles;

    initial begin
        cur_name     = '0;
        cur_errors   = 0;
        cur_cycles   = 0;
        tests_passed = 0;
        tests_failed = 0;
        report_done  = 1'b0;
    end

    // Result line for the test that just ended
    task automatic close_test();
        if (cur_name != '0) begin
            if (cur_errors == 0) begin
                tests_passed++;
                $display("test %0s: pass, %0d cycles checked", cur_name, cur_cycles);
            end else begin
                tests_failed++;
                $display("test %0s: fail, %0d mismatches in %0d cycles",
                         cur_name, cur_errors, cur_cycles);
            end
        end
        cur_errors = 0;
        cur_cycles = 0;
    endtask

    // X on the DUT side counts as a mismatch
    task automatic compare_field(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            cur_errors++;
            $display("[ERROR] %0s line %0d %0s: expected %h, actual %h",
                     test_name, line_no, field, expected, actual);
        end
    endtask

    // Outputs settle right after the edge, so sample late in the cycle
    always @(posedge clk) begin
        #(SAMPLE_DELAY);
        if (trace_done) begin
            // Last test has no successor to close it
            if (!report_done) begin
                close_test();
                report_done = 1'b1;
            end
        end else if (check_en) begin
            if (test_name != cur_name) begin
                close_test();
                cur_name = test_name;
            end
            cur_cycles++;
            compare_field("instruction_dec", exp_instr, instruction_dec);
            compare_field("pc_curr_dec", exp_curr, pc_curr_dec);
            compare_field("pc_next_dec", exp_next, pc_next_dec);
        end
    end

endmodule

/* bench/fetch_trace.txt */
# name  stim(branch interrupt rti rsi flush stall)  branch_target  instr  pc_curr  pc_next
# One line per clock cycle, stimulus for the next edge, expected outputs of this cycle
reset_stream     000000 00000000 00000013 00000000 00000000
reset_stream     000000 00000000 00000013 00000000 00000000
reset_stream     000000 00000000 00000013 00000000 00000000
reset_stream     000000 00000000 00100093 00000000 00000004
reset_stream     000000 00000000 00200113 00000004 00000008
reset_stream     000000 00000000 00300193 00000008 0000000c
reset_stream     000000 00000000 00400213 0000000c 00000010
reset_stream     000000 00000000 00500293 00000010 00000014
reset_stream     000000 00000000 00600313 00000014 00000018
reset_stream     000000 00000000 00000013 00000018 0000001c
reset_stream     000000 00000000 00800393 0000001c 00000020
branch_redirect  000000 00000000 00900413 00000020 00000024
branch_redirect  100000 00000030 00a00493 00000024 00000028
branch_redirect  000000 00000000 00b00513 00000028 0000002c
branch_redirect  000000 00000000 00c00593 0000002c 00000030
branch_redirect  000000 00000000 00d00613 00000030 00000034
branch_redirect  100000 00000008 00e00693 00000034 00000038
branch_redirect  000000 00000000 00f00713 00000038 0000003c
branch_redirect  000000 00000000 01000793 0000003c 00000040
branch_redirect  000000 00000000 00300193 00000008 0000000c
branch_redirect  000000 00000000 00400213 0000000c 00000010
interrupt_return 010000 00000000 00500293 00000010 00000014
interrupt_return 000000 00000000 00600313 00000014 00000018
interrupt_return 000000 00000000 00000013 00000018 0000001c
interrupt_return 001000 00000000 00200113 00000004 00000008
interrupt_return 000000 00000000 00300193 00000008 0000000c
interrupt_return 000000 00000000 00400213 0000000c 00000010
interrupt_return 000100 00000000 00800393 0000001c 00000020
interrupt_return 001000 00000000 00900413 00000020 00000024
interrupt_return 000000 00000000 00a00493 00000024 00000028
interrupt_return 000000 00000000 00b00513 00000028 0000002c
interrupt_return 000000 00000000 00100093 00000000 00000004
interrupt_return 000000 00000000 00200113 00000004 00000008
flush_nops       100010 00000008 00300193 00000008 0000000c
flush_nops       000000 00000000 00000013 00000000 00000000
flush_nops       000000 00000000 00000013 00000000 00000000
flush_nops       000000 00000000 00000013 00000000 00000000
flush_nops       000000 00000000 00400213 0000000c 00000010
flush_nops       000000 00000000 00500293 00000010 00000014
stall_hold       000000 00000000 00600313 00000014 00000018
stall_hold       000000 00000000 00000013 00000018 0000001c
stall_hold       000001 00000000 00800393 0000001c 00000020
stall_hold       100001 0000003c 00800393 0000001c 00000020
stall_hold       000001 00000000 00800393 0000001c 00000020
stall_hold       000000 00000000 00800393 0000001c 00000020
stall_hold       000000 00000000 00900413 00000020 00000024
stall_hold       000000 00000000 00a00493 00000024 00000028
stall_hold       000000 00000000 00b00513 00000028 0000002c

/* bench/tb_fetch.sv */
`timescale 1ns/1ns

module tb_fetch;

    // Inputs change this long after each rising edge
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    // Margin beyond trace length and reset before the run counts as stuck
    localparam int SLACK_CYCLES = 20;
    localparam int NAME_CHARS   = 24;
    localparam string TRACE_FILE = "bench/fetch_trace.txt";

    logic clk;
    logic rst_n;
    logic branch;
    logic interrupt;
    logic rti;
    logic rsi;
    logic flush;
    logic stall;
    logic [31:0] branch_target;
    logic [31:0] instruction_dec;
    logic [31:0] pc_curr_dec;
    logic [31:0] pc_next_dec;

    // Expectations for the current cycle, handed to the monitor
    logic [8*NAME_CHARS-1:0] test_name;
    logic [31:0] exp_instr;
    logic [31:0] exp_curr;
    logic [31:0] exp_next;
    int line_no;
    logic check_en;
    logic trace_done;
    logic report_done;
    int tests_passed;
    int tests_failed;

    // Trace contents, one entry per cycle
    logic [8*NAME_CHARS-1:0] name_q [$];
    logic [5:0]  stim_q [$];
    logic [31:0] target_q [$];
    logic [31:0] instr_q [$];
    logic [31:0] curr_q [$];
    logic [31:0] next_q [$];

    int cycle_count = 0;
    int cycle_limit = 0;

    always #10 clk = ~clk;

    fetch_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .branch          (branch),
        .branch_target   (branch_target),
        .interrupt       (interrupt),
        .rti             (rti),
        .rsi             (rsi),
        .flush           (flush),
        .stall           (stall),
        .instruction_dec (instruction_dec),
        .pc_curr_dec     (pc_curr_dec),
        .pc_next_dec     (pc_next_dec)
    );

    fetch_monitor #(.NAME_CHARS(NAME_CHARS)) u_monitor (
        .clk             (clk),
        .check_en        (check_en),
        .trace_done      (trace_done),
        .test_name       (test_name),
        .line_no         (line_no),
        .exp_instr       (exp_instr),
        .exp_curr        (exp_curr),
        .exp_next        (exp_next),
        .instruction_dec (instruction_dec),
        .pc_curr_dec     (pc_curr_dec),
        .pc_next_dec     (pc_next_dec),
        .tests_passed    (tests_passed),
        .tests_failed    (tests_failed),
        .report_done     (report_done)
    );

    // Whole trace into queues, so the cycle budget is known up front
    task automatic load_trace(output bit ok);
        int fd;
        int rc;
        string line;
        logic [8*NAME_CHARS-1:0] name;
        logic [5:0]  bits;
        logic [31:0] tgt;
        logic [31:0] ins;
        logic [31:0] cur;
        logic [31:0] nxt;
        ok = 1'b0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            // Comment and blank lines carry no cycle
            if (rc == 0 || line.len() == 0 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%s %b %h %h %h %h", name, bits, tgt, ins, cur, nxt) == 6) begin
                name_q.push_back(name);
                stim_q.push_back(bits);
                target_q.push_back(tgt);
                instr_q.push_back(ins);
                curr_q.push_back(cur);
                next_q.push_back(nxt);
            end
        end
        $fclose(fd);
        ok = (name_q.size() > 0);
    endtask

    // Stimulus for the coming edge and expectations for this cycle
    task automatic apply_line(input int idx);
        {branch, interrupt, rti, rsi, flush, stall} = stim_q[idx];
        branch_target = target_q[idx];
        test_name     = name_q[idx];
        exp_instr     = instr_q[idx];
        exp_curr      = curr_q[idx];
        exp_next      = next_q[idx];
        line_no       = idx;
        check_en      = 1'b1;
    endtask

    // Edge counter guards against a run that never ends
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: trace did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        bit ok;
        clk           = 1'b0;
        rst_n         = 1'b0;
        {branch, interrupt, rti, rsi, flush, stall} = '0;
        branch_target = '0;
        test_name     = '0;
        exp_instr     = '0;
        exp_curr      = '0;
        exp_next      = '0;
        line_no       = 0;
        check_en      = 1'b0;
        trace_done    = 1'b0;
        load_trace(ok);
        if (!ok) begin
            $display("Could not read any cycles from %s", TRACE_FILE);
            $display("TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = name_q.size() + RESET_CYCLES + SLACK_CYCLES;
            repeat (RESET_CYCLES) @(posedge clk);
            // Reset drops together with the first trace line
            for (int i = 0; i < name_q.size(); i++) begin
                #(DRIVE_DELAY);
                rst_n = 1'b1;
                apply_line(i);
                @(posedge clk);
            end
            #(DRIVE_DELAY);
            check_en   = 1'b0;
            trace_done = 1'b1;
            wait (report_done);
            $display("Summary: %0d tests passed, %0d failed", tests_passed, tests_failed);
            if (tests_failed == 0 && tests_passed > 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

/* fetch_unit.f */
hdl/fetch_pkg.sv
hdl/instr_mem.sv
hdl/pc_ctrl.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
bench/fetch_monitor.sv
bench/tb_fetch.sv

/* hdl/fetch_pkg.sv */
package fetch_pkg;

    // Byte address as seen by the program counter and the decode stage
    typedef logic [31:0] addr_t;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // Canonical NOP, addi x0 x0 0
    localparam instr_t NOP_WORD = 32'h0000_0013;

    // Interrupt entry point
    localparam addr_t IRQ_VECTOR = 32'h0000_0004;

    // Instruction memory size in 32-bit words
    localparam int IMEM_DEPTH = 16;

    // Word address width
    // Byte address bits [1:0] are dropped before the memory
    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    // Hex image loaded into the instruction memory at start of simulation
    localparam string IMEM_FILE = "imem_image.hex";

    // Number of NOP cycles that follow the flush edge itself
    localparam logic [1:0] FLUSH_CYCLES = 2'd2;

endpackage

/* hdl/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   flush,
    input  logic   stall,
    input  addr_t  fetch_pc,
    input  addr_t  fetch_pc_plus4,
    output logic   pc_hold,
    output instr_t instruction_dec,
    output addr_t  pc_curr_dec,
    output addr_t  pc_next_dec
);

    // Set by reset, cleared after the first edge
    logic warmup;

    // Remaining NOP cycles after a flush
    logic [1:0] flush_cnt;

    // Memory has returned at least one real read since reset
    logic fetch_valid;

    // Memory side
    logic               mem_read_en;
    logic [IMEM_AW-1:0] mem_addr;
    instr_t             mem_word;

    // Addresses of the word currently sitting at the memory output
    addr_t pc_curr_f;
    addr_t pc_next_f;

    // Word after NOP substitution
    instr_t instr_f;

    // Memory word is empty or not loaded
    logic word_bad;

    // Front end freezes during warm-up and stall
    assign pc_hold     = warmup | stall;
    assign mem_read_en = ~pc_hold;

    // Word address from byte address
    assign mem_addr = fetch_pc[IMEM_AW+1:2];

    instr_mem u_instr_mem (
        .clk     (clk),
        .read_en (mem_read_en),
        .addr    (mem_addr),
        .word    (mem_word)
    );

    // Single warm-up cycle after reset keeps the PC at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            warmup <= 1'b1;
        end else begin
            warmup <= 1'b0;
        end
    end

    // Memory output is meaningless until the first enabled read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else if (mem_read_en) begin
            fetch_valid <= 1'b1;
        end
    end

    // Flush counter
    // Loads on the flush edge, then counts down on each unstalled edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_cnt <= '0;
        end else if (flush) begin
            flush_cnt <= FLUSH_CYCLES;
        end else if (!stall && flush_cnt != '0) begin
            flush_cnt <= flush_cnt - 2'd1;
        end
    end

    // Address pair follows the memory read by one stage
    // Keeps instruction and addresses aligned at decode
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_curr_f <= '0;
            pc_next_f <= '0;
        end else if (!pc_hold) begin
            pc_curr_f <= fetch_pc;
            pc_next_f <= fetch_pc_plus4;
        end
    end

    // All-zero or unknown words become NOPs but keep their addresses
    assign word_bad = (mem_word == '0) || $isunknown(mem_word);

    always_comb begin
        if (warmup || !fetch_valid || word_bad) begin
            instr_f = NOP_WORD;
        end else begin
            instr_f = mem_word;
        end
    end

    // Fetch-to-decode register
    // Flush wins over stall, the counter cycles then zero the addresses too
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instruction_dec <= NOP_WORD;
            pc_curr_dec     <= '0;
            pc_next_dec     <= '0;
        end else if (flush) begin
            instruction_dec <= NOP_WORD;
            pc_curr_dec     <= '0;
            pc_next_dec     <= '0;
        end else if (stall) begin
            instruction_dec <= instruction_dec;
            pc_curr_dec     <= pc_curr_dec;
            pc_next_dec     <= pc_next_dec;
        end else if (flush_cnt != '0) begin
            instruction_dec <= NOP_WORD;
            pc_curr_dec     <= '0;
            pc_next_dec     <= '0;
        end else begin
            instruction_dec <= instr_f;
            pc_curr_dec     <= pc_curr_f;
            pc_next_dec     <= pc_next_f;
        end
    end

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   branch,
    input  addr_t  branch_target,
    input  logic   interrupt,
    input  logic   rti,
    input  logic   rsi,
    input  logic   flush,
    input  logic   stall,
    output instr_t instruction_dec,
    output addr_t  pc_curr_dec,
    output addr_t  pc_next_dec
);

    // PC and its successor into the fetch stage
    addr_t fetch_pc;
    addr_t fetch_pc_plus4;

    // Freeze request back to the PC
    logic pc_hold;

    // Next-address selection and return register
    pc_ctrl u_pc_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .interrupt      (interrupt),
        .rti            (rti),
        .rsi            (rsi),
        .branch         (branch),
        .pc_hold        (pc_hold),
        .branch_target  (branch_target),
        .fetch_pc       (fetch_pc),
        .fetch_pc_plus4 (fetch_pc_plus4)
    );

    // Memory read, NOP insertion and decode register
    fetch_stage u_fetch_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .stall           (stall),
        .fetch_pc        (fetch_pc),
        .fetch_pc_plus4  (fetch_pc_plus4),
        .pc_hold         (pc_hold),
        .instruction_dec (instruction_dec),
        .pc_curr_dec     (pc_curr_dec),
        .pc_next_dec     (pc_next_dec)
    );

endmodule

/* hdl/imem_image.hex */
00100093
00200113
00300193
00400213
00500293
00600313
00000000
00800393
00900413
00a00493
00b00513
00c00593
00d00613
00e00693
00f00713
01000793

/* hdl/instr_mem.sv */
`timescale 1ns/1ns

module instr_mem import fetch_pkg::*; (
    input  logic               clk,
    input  logic               read_en,
    input  logic [IMEM_AW-1:0] addr,
    output instr_t             word
);

    // Word array, one entry per instruction
    instr_t rom [IMEM_DEPTH];

    // Program image
    // Missing entries stay unknown and are turned into NOPs downstream
    initial begin
        $readmemh(IMEM_FILE, rom);
    end

    // Registered read, one cycle from address to word
    // With read_en low the last word is kept, so a stalled fetch stays stable
    always_ff @(posedge clk) begin
        if (read_en) begin
            word <= rom[addr];
        end
    end

endmodule

/* hdl/pc_ctrl.sv */
`timescale 1ns/1ns

module pc_ctrl import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  interrupt,
    input  logic  rti,
    input  logic  rsi,
    input  logic  branch,
    input  logic  pc_hold,
    input  addr_t branch_target,
    output addr_t fetch_pc,
    output addr_t fetch_pc_plus4
);

    // Current program counter
    addr_t pc_q;

    // Saved return address for interrupts
    addr_t ret_q;

    // Branch target or sequential successor
    addr_t seq_or_branch;

    // Next PC after priority selection
    addr_t pc_d;

    // Sequential successor of the current fetch
    assign fetch_pc       = pc_q;
    assign fetch_pc_plus4 = pc_q + 32'd4;

    // Lowest two priorities
    // Also the address an interrupt will later return to
    assign seq_or_branch = branch ? branch_target : fetch_pc_plus4;

    // Full priority chain
    // Interrupt first, then return from interrupt, then branch, then sequential
    always_comb begin
        if (interrupt) begin
            pc_d = IRQ_VECTOR;
        end else if (rti) begin
            pc_d = ret_q;
        end else begin
            pc_d = seq_or_branch;
        end
    end

    // Program counter register
    // Held during warm-up and stall, so strobes on a held edge are lost
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!pc_hold) begin
            pc_q <= pc_d;
        end
    end

    // Return address register
    // rsi clears it on any edge, even a held one
    // Interrupt saves the address the interrupted stream would have taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_q <= '0;
        end else if (rsi) begin
            ret_q <= '0;
        end else if (!pc_hold && interrupt) begin
            ret_q <= seq_or_branch;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the fetch unit testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fetch -Mdir obj_dir -f fetch_unit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# The instruction memory loads its image from the working directory
cp hdl/imem_image.hex imem_image.hex
if [ $? -ne 0 ]; then
    echo "Could not place the memory image"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_fetch)
sim_status=$?
rm -f imem_image.hex
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if echo "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
